/* common/alu_pkg.sv */
// ALU shared definitions
package alu_pkg;

    typedef logic [6:0] sel_t;
    typedef logic [2:0] width_t;
    typedef logic [7:0] flags_t;

    localparam sel_t ALU_MOVE = 7'h00;
    localparam sel_t ALU_ADD  = 7'h01;
    localparam sel_t ALU_ADC  = 7'h02;
    localparam sel_t ALU_SUB  = 7'h03;
    localparam sel_t ALU_SBC  = 7'h04;
    localparam sel_t ALU_CP   = 7'h05;
    localparam sel_t ALU_NEG  = 7'h06;
    localparam sel_t ALU_AND  = 7'h07;
    localparam sel_t ALU_OR   = 7'h08;
    localparam sel_t ALU_XOR  = 7'h09;
    localparam sel_t ALU_CPL  = 7'h0a;
    localparam sel_t ALU_RLC  = 7'h10;
    localparam sel_t ALU_RRC  = 7'h11;
    localparam sel_t ALU_RL   = 7'h12;
    localparam sel_t ALU_RR   = 7'h13;
    localparam sel_t ALU_SLA  = 7'h14;
    localparam sel_t ALU_SRA  = 7'h15;
    localparam sel_t ALU_SLL  = 7'h16;
    localparam sel_t ALU_SRL  = 7'h17;
    localparam sel_t ALU_BIT  = 7'h18;
    localparam sel_t ALU_SET  = 7'h19;
    localparam sel_t ALU_RES  = 7'h1a;
    localparam sel_t ALU_CHG  = 7'h1b;
    localparam sel_t ALU_BITX = 7'h1c;
    localparam sel_t ALU_SETX = 7'h1d;
    localparam sel_t ALU_RESX = 7'h1e;
    localparam sel_t ALU_CHGX = 7'h1f;
    localparam sel_t ALU_SCF  = 7'h20;
    localparam sel_t ALU_RCF  = 7'h21;
    localparam sel_t ALU_CCF  = 7'h22;
    localparam sel_t ALU_ZCF  = 7'h23;
    localparam sel_t ALU_EXFF = 7'h24;

    localparam width_t W_BYTE = 3'b001;
    localparam width_t W_WORD = 3'b010;
    localparam width_t W_LONG = 3'b100;

    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    typedef union packed {
        logic [31:0] value;
        struct packed {
            logic [20:0] unused;
            logic [ 2:0] idx;   // bit number in the byte
            logic [ 7:0] data;
        } mem;
    } imm_word_u;

    localparam logic [1:0] SRC_ADDSUB   = 2'd0;
    localparam logic [1:0] SRC_BITSHIFT = 2'd1;
    localparam logic [1:0] SRC_OP2      = 2'd2;
    localparam logic [1:0] SRC_HOLD     = 2'd3;

    // bitshift class is {operand form, function}
    localparam logic [1:0] BSF_LOGIC = 2'd0;
    localparam logic [1:0] BSF_REG   = 2'd1;  // op0 with bit mask
    localparam logic [1:0] BSF_MEM   = 2'd2;  // imm byte with bit mask
    localparam logic [1:0] BSF_SHIFT = 2'd3;

    localparam logic [2:0] BSN_AND  = 3'd0;
    localparam logic [2:0] BSN_OR   = 3'd1;
    localparam logic [2:0] BSN_XOR  = 3'd2;
    localparam logic [2:0] BSN_CPL  = 3'd3;
    localparam logic [2:0] BSN_ANDN = 3'd4;

    localparam logic [1:0] CF_SET = 2'd0;
    localparam logic [1:0] CF_CLR = 2'd1;
    localparam logic [1:0] CF_CPL = 2'd2;
    localparam logic [1:0] CF_NZ  = 2'd3;

    function automatic logic [31:0] width_mask(input width_t w);
        return w[0] ? 32'h0000_00ff : w[1] ? 32'h0000_ffff : 32'hffff_ffff;
    endfunction

    function automatic logic msb_at(input width_t w, input logic [31:0] x);
        return w[0] ? x[7] : w[1] ? x[15] : x[31];
    endfunction

endpackage

/* hdl/alu_decode.sv */
// ALU operation decoder
module alu_decode
    import alu_pkg::*;
(
    input  sel_t       sel,
    output logic       sub,
    output logic       use_carry,
    output logic       neg,
    output logic [4:0] bs_op,
    output logic [1:0] src,
    output logic       upd_s,
    output logic       upd_z,
    output logic       upd_h,
    output logic       upd_v,
    output logic       upd_n,
    output logic       upd_c,
    output logic       set_h,
    output logic       set_n,
    output logic [1:0] carry_fn,
    output logic       exff
);

    logic arith_flags;  // S Z V C from the result

    always_comb begin
        sub         = 1'b0;
        use_carry   = 1'b0;
        neg         = 1'b0;
        bs_op       = {BSF_LOGIC, BSN_AND};
        src         = SRC_HOLD;
        arith_flags = 1'b0;
        upd_h       = 1'b0;
        upd_n       = 1'b0;
        upd_z       = 1'b0;
        upd_c       = 1'b0;
        set_h       = 1'b0;
        set_n       = 1'b0;
        carry_fn    = CF_SET;
        exff        = 1'b0;
        case (sel)
            ALU_MOVE: src = SRC_OP2;
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP: begin
                src         = SRC_ADDSUB;
                arith_flags = 1'b1;
                upd_h       = 1'b1;
                upd_n       = 1'b1;
                sub         = sel == ALU_SUB || sel == ALU_SBC || sel == ALU_CP;
                set_n       = sub;
                use_carry   = sel == ALU_ADC || sel == ALU_SBC;
            end
            ALU_NEG: begin
                src         = SRC_ADDSUB;
                neg         = 1'b1;
                arith_flags = 1'b1;
                upd_n       = 1'b1;
                set_n       = 1'b1;
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                src         = SRC_BITSHIFT;
                arith_flags = 1'b1;
                upd_h       = 1'b1;
                upd_n       = 1'b1;
                set_h       = sel == ALU_AND;  // AND forces H
                bs_op       = {BSF_LOGIC, sel == ALU_AND ? BSN_AND :
                                          sel == ALU_OR  ? BSN_OR : BSN_XOR};
            end
            ALU_CPL: begin
                src   = SRC_BITSHIFT;
                bs_op = {BSF_LOGIC, BSN_CPL};
                upd_h = 1'b1;
                upd_n = 1'b1;
                set_h = 1'b1;
                set_n = 1'b1;
            end
            ALU_RLC, ALU_RRC, ALU_RL, ALU_RR, ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL: begin
                src         = SRC_BITSHIFT;
                bs_op       = {BSF_SHIFT, sel[2:0]};  // codes follow shift order
                arith_flags = 1'b1;
                upd_h       = 1'b1;
                upd_n       = 1'b1;
            end
            ALU_BIT, ALU_BITX: begin
                bs_op = {sel == ALU_BITX ? BSF_MEM : BSF_REG, BSN_AND};
                upd_z = 1'b1;
                upd_h = 1'b1;
                upd_n = 1'b1;
                set_h = 1'b1;
            end
            ALU_SET, ALU_SETX: begin
                src   = SRC_BITSHIFT;
                bs_op = {sel == ALU_SETX ? BSF_MEM : BSF_REG, BSN_OR};
            end
            ALU_RES, ALU_RESX: begin
                src   = SRC_BITSHIFT;
                bs_op = {sel == ALU_RESX ? BSF_MEM : BSF_REG, BSN_ANDN};
            end
            ALU_CHG, ALU_CHGX: begin
                src   = SRC_BITSHIFT;
                bs_op = {sel == ALU_CHGX ? BSF_MEM : BSF_REG, BSN_XOR};
            end
            ALU_SCF, ALU_RCF: begin
                upd_h    = 1'b1;
                upd_n    = 1'b1;
                upd_c    = 1'b1;
                carry_fn = sel == ALU_SCF ? CF_SET : CF_CLR;
            end
            ALU_CCF, ALU_ZCF: begin
                upd_n    = 1'b1;
                upd_c    = 1'b1;
                carry_fn = sel == ALU_CCF ? CF_CPL : CF_NZ;
            end
            ALU_EXFF: exff = 1'b1;
            default: ;
        endcase
        upd_s = arith_flags;
        upd_v = arith_flags;
        upd_z = upd_z | arith_flags;
        upd_c = upd_c | arith_flags;
    end

endmodule

/* execute/alu_addsub.sv */
// Adder and subtractor
module alu_addsub
    import alu_pkg::*;
(
    input  logic [31:0] op0,
    input  logic [31:0] op2,
    input  width_t      w,
    input  logic        sub,
    input  logic        use_carry,
    input  logic        neg,
    input  logic        carry,
    output logic [31:0] sum,
    output logic        half,
    output logic        cout,
    output logic        ovf
);

    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] m;
    logic        cin;
    logic        subtract;
    logic [32:0] za;
    logic [32:0] zb;
    logic [32:0] full;   // unsigned, for carry
    logic [32:0] sa;
    logic [32:0] sb;
    logic [32:0] ext;    // signed, for overflow
    logic [4:0]  nib;

    function automatic logic [32:0] sext(input logic [31:0] x, input width_t wd);
        return wd[0] ? {{25{x[7]}}, x[7:0]} :
               wd[1] ? {{17{x[15]}}, x[15:0]} : {x[31], x};
    endfunction

    always_comb begin
        m        = width_mask(w);
        a        = neg ? 32'd0 : op0;  // NEG is 0 - op0
        b        = neg ? op0 : op2;
        subtract = sub | neg;
        cin      = use_carry & carry;
        za       = {1'b0, a & m};
        zb       = {1'b0, b & m};
        sa       = sext(a, w);
        sb       = sext(b, w);
        if (subtract) begin
            full = za - zb - {32'd0, cin};
            ext  = sa - sb - {32'd0, cin};
            nib  = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
        end else begin
            full = za + zb + {32'd0, cin};
            ext  = sa + sb + {32'd0, cin};
            nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
        end
        sum  = full[31:0] & m;
        half = nib[4];
        cout = w[0] ? full[8] : w[1] ? full[16] : full[32];  // borrow when subtracting
        ovf  = ext[32] ^ msb_at(w, ext[31:0]);
    end

endmodule

/* execute/alu_bitshift.sv */
// Logic, shift and bit datapath
module alu_bitshift
    import alu_pkg::*;
(
    input  logic [31:0] op0,
    input  logic [31:0] op2,
    input  imm_word_u   imm,
    input  width_t      w,
    input  logic [4:0]  bs_op,
    input  logic        carry,
    output logic [31:0] res,
    output logic        shift_c,
    output logic        bit_z
);

    logic [1:0]  form;
    logic [2:0]  fn;
    logic [31:0] m;
    logic        msb;
    logic [31:0] bmask;
    logic [31:0] lhs;
    logic [31:0] rhs;
    logic [31:0] right;
    logic [4:0]  top;
    logic        in_bit;
    logic [31:0] raw;

    assign form = bs_op[4:3];
    assign fn   = bs_op[2:0];

    always_comb begin
        m       = width_mask(w);
        msb     = msb_at(w, op0);
        top     = w[0] ? 5'd7 : w[1] ? 5'd15 : 5'd31;
        bmask   = form == BSF_MEM ? 32'd1 << imm.mem.idx : 32'd1 << op2[3:0];
        lhs     = form == BSF_MEM ? {24'd0, imm.mem.data} : op0;
        rhs     = form == BSF_LOGIC ? op2 : bmask;
        bit_z   = form == BSF_MEM ? ~imm.mem.data[imm.mem.idx] : ~op0[{1'b0, op2[3:0]}];
        right   = (op0 & m) >> 1;
        in_bit  = 1'b0;
        shift_c = 1'b0;  // logic ops clear C
        raw     = lhs;
        if (form == BSF_SHIFT) begin
            case (fn)
                3'd0, 3'd2, 3'd4, 3'd6: begin  // RLC RL SLA SLL
                    in_bit  = fn == 3'd0 ? msb : fn == 3'd2 ? carry : 1'b0;
                    raw     = {op0[30:0], in_bit};
                    shift_c = msb;
                end
                default: begin  // RRC RR SRA SRL
                    in_bit  = fn == 3'd1 ? op0[0] :
                              fn == 3'd3 ? carry :
                              fn == 3'd5 ? msb : 1'b0;
                    raw     = right | ({31'd0, in_bit} << top);
                    shift_c = op0[0];
                end
            endcase
        end else begin
            case (fn)
                BSN_AND:  raw = lhs & rhs;
                BSN_OR:   raw = lhs | rhs;
                BSN_XOR:  raw = lhs ^ rhs;
                BSN_CPL:  raw = ~op2;
                BSN_ANDN: raw = lhs & ~rhs;
                default:  raw = lhs;
            endcase
        end
        res = raw & m;
    end

endmodule

/* hdl/alu_result.sv */
// ALU result and flag registers
module alu_result
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  width_t      w,
    input  logic        flag_we,
    input  logic [1:0]  src,
    input  logic        upd_s,
    input  logic        upd_z,
    input  logic        upd_h,
    input  logic        upd_v,
    input  logic        upd_n,
    input  logic        upd_c,
    input  logic        set_h,
    input  logic        set_n,
    input  logic [1:0]  carry_fn,
    input  logic        exff,
    input  logic [31:0] sum,
    input  logic        half,
    input  logic        cout,
    input  logic        ovf,
    input  logic [31:0] res,
    input  logic        shift_c,
    input  logic        bit_z,
    input  logic [31:0] op2,
    output logic [31:0] dout,
    output flags_t      flags,
    output width_t      alu_we,
    output logic        flag_only
);

    logic [31:0] nx_dout;
    flags_t      cand;
    flags_t      upd_m;
    flags_t      nx_flags;
    flags_t      fdash;     // shadow flags
    logic        flag_wel;
    logic        flag_en;
    logic        cf_c;

    always_comb begin
        case (src)
            SRC_ADDSUB:   nx_dout = sum;
            SRC_BITSHIFT: nx_dout = res;
            SRC_OP2:      nx_dout = op2 & width_mask(w);
            default:      nx_dout = dout;
        endcase
        case (carry_fn)
            CF_SET:  cf_c = 1'b1;
            CF_CLR:  cf_c = 1'b0;
            CF_CPL:  cf_c = ~flags[FLAG_C];
            default: cf_c = ~flags[FLAG_Z];
        endcase
        cand         = '0;
        cand[FLAG_S] = msb_at(w, nx_dout);
        cand[FLAG_Z] = src == SRC_HOLD ? bit_z : (nx_dout & width_mask(w)) == 32'd0;
        cand[FLAG_H] = src == SRC_ADDSUB ? half : set_h;
        cand[FLAG_V] = src == SRC_ADDSUB ? ovf :
                       w[0] ? ~^nx_dout[7:0] : ~^nx_dout[15:0];  // even parity
        cand[FLAG_N] = set_n;
        cand[FLAG_C] = src == SRC_ADDSUB ? cout : src == SRC_BITSHIFT ? shift_c : cf_c;
        upd_m         = '0;
        upd_m[FLAG_S] = upd_s;
        upd_m[FLAG_Z] = upd_z;
        upd_m[FLAG_H] = upd_h;
        upd_m[FLAG_V] = upd_v;
        upd_m[FLAG_N] = upd_n;
        upd_m[FLAG_C] = upd_c;
        nx_flags = (cand & upd_m) | (flags & ~upd_m);
    end

    assign flag_en = w != 3'd0 || (flag_we && !flag_wel);  // held flag_we acts once

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout      <= 32'd0;
            flags     <= '0;
            fdash     <= '0;
            alu_we    <= '0;
            flag_only <= 1'b0;
            flag_wel  <= 1'b0;
        end else begin
            flag_wel  <= flag_we;
            flag_only <= flag_we;
            alu_we    <= w;
            if (w != 3'd0) begin
                dout <= nx_dout;
            end
            if (flag_en) begin
                if (exff) begin
                    flags <= fdash;
                    fdash <= flags;
                end else begin
                    flags <= nx_flags;
                end
            end
        end
    end

endmodule

/* hdl/alu_top.sv */
// 32-bit ALU top level
module alu_top
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] op0,      // destination
    input  logic [31:0] op1,      // source
    input  logic [31:0] imm,
    input  logic        sel_imm,
    input  sel_t        sel,
    input  width_t      w,
    input  logic        flag_we,
    output logic [31:0] dout,
    output flags_t      flags,
    output width_t      alu_we,
    output logic        flag_only
);

    logic [31:0] op2;
    logic        sub;
    logic        use_carry;
    logic        neg;
    logic [4:0]  bs_op;
    logic [1:0]  src;
    logic        upd_s;
    logic        upd_z;
    logic        upd_h;
    logic        upd_v;
    logic        upd_n;
    logic        upd_c;
    logic        set_h;
    logic        set_n;
    logic [1:0]  carry_fn;
    logic        exff;
    logic [31:0] sum;
    logic        half;
    logic        cout;
    logic        ovf;
    logic [31:0] res;
    logic        shift_c;
    logic        bit_z;

    assign op2 = sel_imm ? imm : op1;

    alu_decode i_decode (
        .sel(sel), .sub(sub), .use_carry(use_carry), .neg(neg), .bs_op(bs_op),
        .src(src), .upd_s(upd_s), .upd_z(upd_z), .upd_h(upd_h), .upd_v(upd_v),
        .upd_n(upd_n), .upd_c(upd_c), .set_h(set_h), .set_n(set_n),
        .carry_fn(carry_fn), .exff(exff)
    );

    alu_addsub i_addsub (
        .op0(op0), .op2(op2), .w(w), .sub(sub), .use_carry(use_carry), .neg(neg),
        .carry(flags[FLAG_C]), .sum(sum), .half(half), .cout(cout), .ovf(ovf)
    );

    alu_bitshift i_bitshift (
        .op0(op0), .op2(op2), .imm(imm), .w(w), .bs_op(bs_op),
        .carry(flags[FLAG_C]), .res(res), .shift_c(shift_c), .bit_z(bit_z)
    );

    alu_result i_result (
        .clk(clk), .rst(rst), .w(w), .flag_we(flag_we), .src(src),
        .upd_s(upd_s), .upd_z(upd_z), .upd_h(upd_h), .upd_v(upd_v),
        .upd_n(upd_n), .upd_c(upd_c), .set_h(set_h), .set_n(set_n),
        .carry_fn(carry_fn), .exff(exff), .sum(sum), .half(half), .cout(cout),
        .ovf(ovf), .res(res), .shift_c(shift_c), .bit_z(bit_z), .op2(op2),
        .dout(dout), .flags(flags), .alu_we(alu_we), .flag_only(flag_only)
    );

endmodule

/* verification/alu_ref.svh */
// ALU reference model
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

logic [31:0] lfsr = 32'hdf6b8c9a;

// fibonacci form with taps 32 22 2 1
function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < count; i++) begin
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        r    = {r[30:0], lfsr[0]};
    end
    return r;
endfunction

// one operation against the model state d, f, sh
function automatic void alu_model(input sel_t s, input width_t wd, input logic [31:0] a,
                                  input logic [31:0] b, input imm_word_u im, input logic en,
                                  inout logic [31:0] d, inout flags_t f, inout flags_t sh);
    logic [31:0] m;
    logic [31:0] top;
    logic [31:0] av;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] r;
    logic [31:0] bitm;
    logic [63:0] t;
    logic        cin;
    logic        fill;
    logic        arith;
    logic        par;
    logic        mem;
    logic        v;
    logic        c;
    flags_t      nf;
    flags_t      hold;

    m     = wd[0] ? 32'h0000_00ff : wd[1] ? 32'h0000_ffff : 32'hffff_ffff;
    top   = m ^ (m >> 1);  // msb of the active width
    av    = a & m;
    r     = d;
    nf    = f;
    arith = 1'b0;
    par   = 1'b0;
    v     = 1'b0;
    c     = 1'b0;
    cin   = f[FLAG_C] && (s == ALU_ADC || s == ALU_SBC);
    mem   = s == ALU_SETX || s == ALU_RESX || s == ALU_CHGX;
    case (s)
        ALU_MOVE: r = b & m;
        ALU_ADD, ALU_ADC: begin
            x          = av;
            y          = b & m;
            t          = 64'(x) + 64'(y) + 64'(cin);
            r          = t[31:0] & m;
            c          = t > 64'(m);
            v          = ((x & top) == (y & top)) && ((r & top) != (x & top));
            nf[FLAG_H] = 64'(x[3:0]) + 64'(y[3:0]) + 64'(cin) > 64'd15;
            nf[FLAG_N] = 1'b0;
            arith      = 1'b1;
        end
        ALU_SUB, ALU_SBC, ALU_CP, ALU_NEG: begin
            x = s == ALU_NEG ? 32'd0 : av;
            y = s == ALU_NEG ? av : b & m;
            t = 64'(x) - 64'(y) - 64'(cin);
            r = t[31:0] & m;
            c = 64'(x) < 64'(y) + 64'(cin);  // borrow
            v = ((x & top) != (y & top)) && ((r & top) != (x & top));
            if (s != ALU_NEG) begin
                nf[FLAG_H] = 64'(x[3:0]) < 64'(y[3:0]) + 64'(cin);
            end
            nf[FLAG_N] = 1'b1;
            arith      = 1'b1;
        end
        ALU_AND, ALU_OR, ALU_XOR: begin
            r          = s == ALU_AND ? a & b : s == ALU_OR ? a | b : a ^ b;
            r          = r & m;
            nf[FLAG_H] = s == ALU_AND;
            nf[FLAG_N] = 1'b0;
            arith      = 1'b1;
            par        = 1'b1;
        end
        ALU_CPL: begin
            r          = ~b & m;
            nf[FLAG_H] = 1'b1;
            nf[FLAG_N] = 1'b1;
        end
        ALU_RLC, ALU_RL, ALU_SLA, ALU_SLL: begin
            c          = (av & top) != 32'd0;
            fill       = s == ALU_RLC ? c : s == ALU_RL ? f[FLAG_C] : 1'b0;
            r          = ((av << 1) | 32'(fill)) & m;
            nf[FLAG_H] = 1'b0;
            nf[FLAG_N] = 1'b0;
            arith      = 1'b1;
            par        = 1'b1;
        end
        ALU_RRC, ALU_RR, ALU_SRA, ALU_SRL: begin
            c          = av[0];
            fill       = s == ALU_RRC ? av[0] : s == ALU_RR ? f[FLAG_C] :
                         s == ALU_SRA ? (av & top) != 32'd0 : 1'b0;
            r          = (av >> 1) | (fill ? top : 32'd0);
            nf[FLAG_H] = 1'b0;
            nf[FLAG_N] = 1'b0;
            arith      = 1'b1;
            par        = 1'b1;
        end
        ALU_BIT, ALU_BITX: begin
            nf[FLAG_Z] = s == ALU_BIT ? ~a[{1'b0, b[3:0]}] : ~im.mem.data[im.mem.idx];
            nf[FLAG_H] = 1'b1;
            nf[FLAG_N] = 1'b0;
        end
        ALU_SET, ALU_RES, ALU_CHG, ALU_SETX, ALU_RESX, ALU_CHGX: begin
            x    = mem ? 32'(im.mem.data) : a;
            bitm = mem ? 32'd1 << im.mem.idx : 32'd1 << b[3:0];
            if (s == ALU_SET || s == ALU_SETX) begin
                r = x | bitm;
            end else if (s == ALU_RES || s == ALU_RESX) begin
                r = x & ~bitm;
            end else begin
                r = x ^ bitm;
            end
            r = r & m;
        end
        ALU_SCF, ALU_RCF: begin
            nf[FLAG_H] = 1'b0;
            nf[FLAG_N] = 1'b0;
            nf[FLAG_C] = s == ALU_SCF;
        end
        ALU_CCF, ALU_ZCF: begin
            nf[FLAG_N] = 1'b0;
            nf[FLAG_C] = s == ALU_CCF ? ~f[FLAG_C] : ~f[FLAG_Z];
        end
        default: ;
    endcase
    if (par) begin
        v = wd[0] ? ~^r[7:0] : ~^r[15:0];  // 1 on even parity
    end
    if (arith) begin
        nf[FLAG_S] = (r & top) != 32'd0;
        nf[FLAG_Z] = r == 32'd0;
        nf[FLAG_V] = v;
        nf[FLAG_C] = c;
    end
    if (wd != 3'd0) begin
        d = r;
    end
    if (en && s == ALU_EXFF) begin
        hold = f;
        f    = sh;
        sh   = hold;
    end else if (en) begin
        f = nf;
    end
endfunction

`endif

/* verification/alu_tb.sv */
// ALU testbench
module alu_tb
    import alu_pkg::*;
();

    localparam int PERIOD          = 20;
    localparam int N_RAND          = 16;  // per code and width
    localparam int WATCHDOG_CYCLES = 27 * 3 * N_RAND + 200;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] op0;
    logic [31:0] op1;
    logic [31:0] imm;
    logic        sel_imm;
    sel_t        sel;
    width_t      w;
    logic        flag_we;
    logic [31:0] dout;
    flags_t      flags;
    width_t      alu_we;
    logic        flag_only;

    logic [31:0] m_dout = '0;
    flags_t      m_flags = '0;
    flags_t      m_shadow = '0;
    logic        m_prev_we = 1'b0;

    logic [31:0] exp_dout_q[$];
    flags_t      exp_flags_q[$];
    width_t      exp_we_q[$];
    logic        exp_fo_q[$];
    string       name_q[$];

    logic        have_pending = 1'b0;
    logic [31:0] p_dout;
    flags_t      p_flags;
    width_t      p_we;
    logic        p_fo;
    string       p_name;
    int          checks = 0;
    int          errors = 0;
    int          checks_mark = 0;
    int          errors_mark = 0;

    `include "alu_ref.svh"

    alu_top i_dut (
        .clk(clk), .rst(rst), .op0(op0), .op1(op1), .imm(imm), .sel_imm(sel_imm),
        .sel(sel), .w(w), .flag_we(flag_we), .dout(dout), .flags(flags),
        .alu_we(alu_we), .flag_only(flag_only)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic issue_op(input string name, input sel_t s, input width_t wd,
                            input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] im, input logic si, input logic fwe);
        logic [31:0] op2v;
        logic        en;
        @(posedge clk);
        op0     <= a;
        op1     <= b;
        imm     <= im;
        sel_imm <= si;
        sel     <= s;
        w       <= wd;
        flag_we <= fwe;
        op2v = si ? im : b;
        en   = wd != 3'd0 || (fwe && !m_prev_we);  // held flag_we acts once
        alu_model(s, wd, a, op2v, im, en, m_dout, m_flags, m_shadow);
        m_prev_we = fwe;
        exp_dout_q.push_back(m_dout);
        exp_flags_q.push_back(m_flags);
        exp_we_q.push_back(wd);
        exp_fo_q.push_back(fwe);
        name_q.push_back($sformatf("%s sel=%h w=%b", name, s, wd));
    endtask

    task automatic run_range(input string name, input sel_t first, input sel_t last);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] im;
        logic [31:0] pick;
        int          code;
        int          k;
        for (code = 32'(first); code <= 32'(last); code++) begin
            for (k = 0; k < 3; k++) begin
                repeat (N_RAND) begin
                    a    = rand_bits(32);
                    b    = rand_bits(32);
                    im   = rand_bits(32);
                    pick = rand_bits(1);
                    issue_op(name, sel_t'(code), 3'b001 << k, a, b, im, pick[0], 1'b0);
                end
            end
        end
    endtask

    task automatic flag_pulse(input string name, input sel_t s, input int hold);
        repeat (hold) issue_op(name, s, 3'b000, '0, '0, '0, 1'b0, 1'b1);
        issue_op(name, ALU_MOVE, 3'b000, '0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic finish_test(input string name);
        issue_op(name, ALU_MOVE, 3'b000, '0, '0, '0, 1'b0, 1'b0);
        repeat (2) @(negedge clk);
        @(posedge clk);  // last compare is done by now
        $display("%-8s %0d checks, %0d errors", name, checks - checks_mark,
                 errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    // result of the op issued before the last rising edge
    always @(negedge clk) begin
        if (have_pending) begin
            checks++;
            assert (dout === p_dout) else begin
                $display("FAILED %s dout expected %h actual %h", p_name, p_dout, dout);
                errors++;
            end
            assert (flags === p_flags) else begin
                $display("FAILED %s flags expected %h actual %h", p_name, p_flags, flags);
                errors++;
            end
            assert (alu_we === p_we) else begin
                $display("FAILED %s alu_we expected %b actual %b", p_name, p_we, alu_we);
                errors++;
            end
            assert (flag_only === p_fo) else begin
                $display("FAILED %s flag_only expected %b actual %b", p_name, p_fo,
                         flag_only);
                errors++;
            end
        end
        have_pending = name_q.size() != 0;
        if (have_pending) begin
            p_name  = name_q.pop_front();
            p_dout  = exp_dout_q.pop_front();
            p_flags = exp_flags_q.pop_front();
            p_we    = exp_we_q.pop_front();
            p_fo    = exp_fo_q.pop_front();
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("timeout after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        op0     = '0;
        op1     = '0;
        imm     = '0;
        sel_imm = 1'b0;
        sel     = ALU_MOVE;
        w       = '0;
        flag_we = 1'b0;
        repeat (3) @(posedge clk);
        repeat (2) issue_op("reset", ALU_MOVE, 3'b000, '0, '0, '0, 1'b0, 1'b0);  // first in reset
        rst <= 1'b0;
        finish_test("reset");
        run_range("addsub", ALU_ADD, ALU_NEG);
        finish_test("addsub");
        run_range("logic", ALU_MOVE, ALU_MOVE);
        run_range("logic", ALU_AND, ALU_CPL);
        finish_test("logic");
        run_range("shift", ALU_RLC, ALU_SRL);
        finish_test("shift");
        run_range("bitops", ALU_BIT, ALU_CHGX);
        finish_test("bitops");
        issue_op("flagops", ALU_ADD, W_BYTE, 32'd0, 32'd0, '0, 1'b0, 1'b0);  // Z set
        issue_op("flagops", ALU_CPL, W_BYTE, '0, '0, '0, 1'b0, 1'b0);  // H and N set
        flag_pulse("flagops", ALU_SCF, 1);
        flag_pulse("flagops", ALU_ZCF, 1);
        flag_pulse("flagops", ALU_CCF, 1);
        issue_op("flagops", ALU_CPL, W_BYTE, '0, '0, '0, 1'b0, 1'b0);
        flag_pulse("flagops", ALU_RCF, 1);
        issue_op("flagops", ALU_SUB, W_BYTE, 32'd5, 32'd3, '0, 1'b0, 1'b0);  // Z clear
        flag_pulse("flagops", ALU_ZCF, 1);
        flag_pulse("flagops", ALU_CCF, 2);
        flag_pulse("flagops", ALU_SCF, 1);
        flag_pulse("flagops", ALU_EXFF, 1);
        flag_pulse("flagops", ALU_EXFF, 1);
        finish_test("flagops");
        $display("total %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+verification
common/alu_pkg.sv
hdl/alu_decode.sv
execute/alu_addsub.sv
execute/alu_bitshift.sv
hdl/alu_result.sv
hdl/alu_top.sv
verification/alu_tb.sv

/* Makefile */
TOP := alu_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the ALU testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
